/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_fetch_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
hw/fetch_pkg.sv
hw/line_cache.sv
hw/axi_read_master.sv
hw/ifetch.sv
hw/fetch_top.sv
verification/axi_rom_model.sv
verification/tb_fetch_top.sv

/* hw/axi_read_master.sv */
`timescale 1ns/1ps

module axi_read_master (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic read_req,
	input fetch_pkg::line_addr_t read_line,
	output logic read_busy,
	output logic read_done,
	output logic read_error,
	output fetch_pkg::line_t read_data,
	output fetch_pkg::axi_ar_t ar,
	input logic arready,
	input fetch_pkg::axi_r_t r,
	output logic rready
);

	typedef enum logic [1:0] {
		STATE_IDLE,
		STATE_ADDR,    // arvalid held until arready
		STATE_WAIT,    // Address accepted, waiting for rvalid
		STATE_DISCARD  // Read was flushed, drain its response
	} state_e;

	state_e state;
	fetch_pkg::line_addr_t pending_line;

	// Flush blocks both handshakes in its own cycle so no transfer slips through
	assign ar.arvalid = state == STATE_ADDR && !flush;
	assign ar.araddr = {pending_line, {fetch_pkg::ALIGN_BITS{1'b0}}};
	assign rready = (state == STATE_WAIT || state == STATE_DISCARD) && !flush;

	assign read_busy = state != STATE_IDLE;

	// Data and error are only meaningful together with read_done
	assign read_done = state == STATE_WAIT && r.rvalid && rready;
	assign read_data = r.rdata;
	assign read_error = r.rresp != fetch_pkg::OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= STATE_IDLE;
		end else begin
			case (state)
				STATE_IDLE: begin
					if (read_req && !flush)
						state <= STATE_ADDR;
				end
				STATE_ADDR: begin
					if (flush)
						state <= STATE_IDLE; // Nothing was accepted, so nothing to drain
					else if (arready)
						state <= STATE_WAIT;
				end
				STATE_WAIT: begin
					if (flush)
						state <= STATE_DISCARD;
					else if (r.rvalid)
						state <= STATE_IDLE;
				end
				STATE_DISCARD: begin
					// The slave keeps rvalid up until we take it
					if (r.rvalid && rready)
						state <= STATE_IDLE;
				end
				default: state <= STATE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == STATE_IDLE && read_req)
			pending_line <= read_line;
	end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

	// Datapath widths
	localparam int ALEN = 32;
	localparam int ILEN = 32;
	localparam int LINE_BITS = 64;
	localparam int ALIGN_BITS = 3; // Byte offset bits inside one line

	// Cache geometry
	localparam int CACHE_INDEX_BITS = 4;
	localparam int CACHE_LINES = 1 << CACHE_INDEX_BITS;
	localparam int LINE_ADDR_BITS = ALEN - ALIGN_BITS;
	localparam int TAG_BITS = LINE_ADDR_BITS - CACHE_INDEX_BITS;
	localparam int PARCELS_PER_LINE = LINE_BITS / 16;

	typedef logic [ALEN-1:0] addr_t;
	typedef logic [ILEN-1:0] instr_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [LINE_ADDR_BITS-1:0] line_addr_t; // Byte address without the offset bits
	typedef logic [CACHE_INDEX_BITS-1:0] cache_index_t;
	typedef logic [TAG_BITS-1:0] cache_tag_t;
	typedef logic [15:0] parcel_t; // Smallest unit of the instruction stream

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// AXI4-Lite read address channel, master to slave
	typedef struct packed {
		logic arvalid;
		addr_t araddr;
	} axi_ar_t;

	// Address channel ready, slave to master
	typedef struct packed {
		logic arready;
	} axi_ar_rdy_t;

	// AXI4-Lite read data channel, slave to master
	typedef struct packed {
		logic rvalid;
		line_t rdata;
		axi_resp_e rresp;
	} axi_r_t;

	// One fetched instruction as seen by the decode stage
	// A 16-bit instruction sits zero-extended in the low half of instruction
	typedef struct packed {
		instr_t instruction;
		addr_t instr_addr;
		addr_t next_addr;
		logic exception;
	} fetch_out_t;

endpackage

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input logic clk,
	input logic rst,
	input logic flush,
	input fetch_pkg::addr_t pc,
	input logic consumer_stall,
	output fetch_pkg::fetch_out_t out,
	output logic out_valid,
	output fetch_pkg::axi_ar_t ar,
	input logic arready,
	input fetch_pkg::axi_r_t r,
	output logic rready
);

	// Line read requests between the fetch FSM and the bus master
	logic read_req;
	fetch_pkg::line_addr_t read_line;
	logic read_busy;
	logic read_done;
	logic read_error;
	fetch_pkg::line_t read_data;

	ifetch i_ifetch (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.pc(pc),
		.consumer_stall(consumer_stall),
		.out(out),
		.out_valid(out_valid),
		.read_req(read_req),
		.read_line(read_line),
		.read_busy(read_busy),
		.read_done(read_done),
		.read_error(read_error),
		.read_data(read_data)
	);

	axi_read_master i_axi_read_master (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.read_req(read_req),
		.read_line(read_line),
		.read_busy(read_busy),
		.read_done(read_done),
		.read_error(read_error),
		.read_data(read_data),
		.ar(ar),
		.arready(arready),
		.r(r),
		.rready(rready)
	);

endmodule

/* hw/ifetch.sv */
`timescale 1ns/1ps

module ifetch (
	input logic clk,
	input logic rst,
	input logic flush,
	input fetch_pkg::addr_t pc,
	input logic consumer_stall,
	output fetch_pkg::fetch_out_t out,
	output logic out_valid,
	output logic read_req,
	output fetch_pkg::line_addr_t read_line,
	input logic read_busy,
	input logic read_done,
	input logic read_error,
	input fetch_pkg::line_t read_data
);

	typedef enum logic [2:0] {
		STATE_START,   // Sample pc
		STATE_LOOKUP,  // Look up the active line and emit when it hits
		STATE_REQUEST, // Issue a line read once the bus master is free
		STATE_WAIT,    // Wait for the line, which then goes into the cache
		STATE_RAISE,   // Present the exception output
		STATE_HALT     // Sticky until flush or reset
	} state_e;

	state_e state;
	state_e state_next;

	fetch_pkg::addr_t fetch_pc;
	fetch_pkg::line_addr_t next_line; // Always the line following fetch_pc
	logic second_half;                // Working on the 2nd line of a split instruction
	fetch_pkg::parcel_t upper_half;   // Low parcel of a split instruction

	fetch_pkg::line_addr_t active_line;
	fetch_pkg::line_t cache_data;
	logic cache_hit;
	logic cache_write;

	logic [fetch_pkg::ALIGN_BITS-2:0] parcel_index;
	logic [fetch_pkg::LINE_BITS+15:0] padded_line;
	fetch_pkg::parcel_t parcel;
	logic compressed;
	logic length_fault;
	logic crosses_line;
	fetch_pkg::instr_t whole_instr;
	fetch_pkg::instr_t joined_instr;
	fetch_pkg::addr_t step_pc;

	logic slot_free;
	logic present;
	logic advance;
	logic stash;
	fetch_pkg::fetch_out_t out_next;

	// The line being worked on is the one holding fetch_pc, or the next one
	// while a split instruction is being completed
	assign active_line = second_half ? next_line
		: fetch_pc[fetch_pkg::ALEN-1:fetch_pkg::ALIGN_BITS];

	line_cache i_line_cache (
		.clk(clk),
		.rst(rst),
		.write_enable(cache_write),
		.write_line(active_line),
		.write_data(read_data),
		.read_line(active_line),
		.read_data(cache_data),
		.hit(cache_hit)
	);

	// A fill always targets the line that was requested, and fetch_pc does not
	// move while a read is outstanding
	assign read_req = state == STATE_REQUEST && !read_busy;
	assign read_line = active_line;
	assign cache_write = state == STATE_WAIT && read_done && !read_error;

	// Instruction extraction from the looked up line
	assign parcel_index = fetch_pc[fetch_pkg::ALIGN_BITS-1:1];
	assign padded_line = {16'b0, cache_data}; // Keeps the 32-bit slice in range at the last parcel
	assign parcel = cache_data[16*parcel_index +: 16];
	assign compressed = parcel[1:0] != 2'b11;
	assign length_fault = parcel[4:0] == 5'b11111; // Encodings longer than 32 bits
	assign crosses_line = !compressed && parcel_index == fetch_pkg::PARCELS_PER_LINE - 1;
	assign whole_instr = compressed ? fetch_pkg::instr_t'(parcel)
		: padded_line[16*parcel_index +: fetch_pkg::ILEN];
	assign joined_instr = {cache_data[15:0], upper_half};

	// A split instruction is always 32 bits, the parcel seen then is from the next line
	assign step_pc = fetch_pc + ((second_half || !compressed)
		? fetch_pkg::addr_t'(4) : fetch_pkg::addr_t'(2));

	// Output register is free when empty or being taken at this edge
	assign slot_free = !out_valid || !consumer_stall;

	always_comb begin
		state_next = state;
		present = 1'b0;
		advance = 1'b0;
		stash = 1'b0;
		out_next.instruction = second_half ? joined_instr : whole_instr;
		out_next.instr_addr = fetch_pc;
		out_next.next_addr = step_pc;
		out_next.exception = 1'b0;

		case (state)
			STATE_START: begin
				state_next = pc[0] ? STATE_RAISE : STATE_LOOKUP;
			end
			STATE_LOOKUP: begin
				if (!cache_hit) begin
					state_next = STATE_REQUEST;
				end else if (second_half) begin
					present = slot_free;
					advance = slot_free;
				end else if (length_fault) begin
					state_next = STATE_RAISE;
				end else if (crosses_line) begin
					stash = 1'b1; // Keep the low half and look up the next line
				end else begin
					present = slot_free;
					advance = slot_free;
				end
			end
			STATE_REQUEST: begin
				if (!read_busy)
					state_next = STATE_WAIT;
			end
			STATE_WAIT: begin
				// The fresh line is looked up again from the cache next cycle
				if (read_done)
					state_next = read_error ? STATE_RAISE : STATE_LOOKUP;
			end
			STATE_RAISE: begin
				if (slot_free) begin
					present = 1'b1;
					out_next.instruction = '0;
					out_next.next_addr = fetch_pc;
					out_next.exception = 1'b1;
					state_next = STATE_HALT;
				end
			end
			STATE_HALT: begin
				state_next = STATE_HALT;
			end
			default: state_next = STATE_START;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= STATE_START;
			second_half <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			state <= state_next;

			if (stash)
				second_half <= 1'b1;
			else if (advance)
				second_half <= 1'b0;

			if (present)
				out_valid <= 1'b1;
			else if (!consumer_stall)
				out_valid <= 1'b0; // Taken with nothing new behind it
		end
	end

	always_ff @(posedge clk) begin
		if (state == STATE_START) begin
			fetch_pc <= pc;
			next_line <= pc[fetch_pkg::ALEN-1:fetch_pkg::ALIGN_BITS] + 1'b1;
		end else if (advance) begin
			fetch_pc <= step_pc;
			// Steps are shorter than a line, so bit 3 toggles exactly on a line change
			if (step_pc[fetch_pkg::ALIGN_BITS] != fetch_pc[fetch_pkg::ALIGN_BITS])
				next_line <= next_line + 1'b1;
		end

		if (stash)
			upper_half <= parcel;

		if (present)
			out <= out_next;
	end

endmodule

/* hw/line_cache.sv */
`timescale 1ns/1ps

module line_cache (
	input logic clk,
	input logic rst,
	input logic write_enable,
	input fetch_pkg::line_addr_t write_line,
	input fetch_pkg::line_t write_data,
	input fetch_pkg::line_addr_t read_line,
	output fetch_pkg::line_t read_data,
	output logic hit
);

	fetch_pkg::line_t data_mem [fetch_pkg::CACHE_LINES];
	fetch_pkg::cache_tag_t tag_mem [fetch_pkg::CACHE_LINES];
	logic [fetch_pkg::CACHE_LINES-1:0] line_valid;

	fetch_pkg::cache_index_t read_index;
	fetch_pkg::cache_index_t write_index;
	fetch_pkg::cache_tag_t read_tag;
	fetch_pkg::cache_tag_t write_tag;

	// Low bits of the line number pick the entry, the rest is the tag
	assign read_index = read_line[fetch_pkg::CACHE_INDEX_BITS-1:0];
	assign read_tag = read_line[fetch_pkg::LINE_ADDR_BITS-1:fetch_pkg::CACHE_INDEX_BITS];
	assign write_index = write_line[fetch_pkg::CACHE_INDEX_BITS-1:0];
	assign write_tag = write_line[fetch_pkg::LINE_ADDR_BITS-1:fetch_pkg::CACHE_INDEX_BITS];

	always_ff @(posedge clk) begin
		if (rst) begin
			line_valid <= '0;
		end else if (write_enable) begin
			line_valid[write_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write_enable) begin
			data_mem[write_index] <= write_data;
			tag_mem[write_index] <= write_tag;
		end
	end

	// Lookup is combinational, a write lands only at the clock edge
	assign read_data = data_mem[read_index];
	assign hit = line_valid[read_index] && tag_mem[read_index] == read_tag;

endmodule

/* verification/axi_rom_model.sv */
`timescale 1ns/1ps

module axi_rom_model #(
	parameter int PARCELS = 256,
	parameter fetch_pkg::addr_t ERR_ADDR = 32'h1c0,   // Reads of this line answer SLVERR
	parameter fetch_pkg::addr_t FAULT_ADDR = 32'h132, // Parcel with a too-long length code
	parameter int MAX_LATENCY = 8
) (
	input logic clk,
	input logic rst,
	input fetch_pkg::axi_ar_t ar,
	output logic arready,
	output fetch_pkg::axi_r_t r,
	input logic rready,
	output int unsigned read_count
);

	fetch_pkg::parcel_t mem [PARCELS];
	fetch_pkg::addr_t req_addr;
	logic busy;
	int unsigned delay;
	int seed = 63;

	// Lengths repeat as 2,4,2,2,4,4 so 32-bit instructions start at every parcel
	// offset over time, the last parcel of a line included
	initial begin : build_image
		fetch_pkg::addr_t a;
		logic [15:0] mix;
		int k;
		a = '0;
		k = 0;
		while (a < 2 * PARCELS) begin
			mix = a[31:16] ^ {a[7:0], a[15:8]} ^ 16'h5ac3;
			if ((k % 6 == 1 || k % 6 >= 4) && a + 4 <= 2 * PARCELS) begin
				mem[a >> 1] = {mix[15:5], 1'b0, mix[3:2], 2'b11}; // Bit 4 clear keeps it 32-bit
				mem[(a >> 1) + 1] = ~mix;
				a = a + 4;
			end else begin
				mem[a >> 1] = {mix[15:2], 1'b0, mix[0]};
				a = a + 2;
			end
			k++;
		end
		mem[FAULT_ADDR >> 1] = 16'h4a5f; // Low five bits all set
	end

	function automatic fetch_pkg::line_t line_at(fetch_pkg::addr_t a);
		fetch_pkg::line_t line;
		int i;
		for (i = 0; i < 4; i++)
			line[16*i +: 16] = mem[((a >> 1) + i) % PARCELS];
		return line;
	endfunction

	assign arready = !busy; // One read at a time

	always @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			r <= '0;
			read_count <= 0;
		end else if (!busy) begin
			if (ar.arvalid) begin
				busy <= 1'b1;
				req_addr <= ar.araddr;
				delay <= $unsigned($random(seed)) % MAX_LATENCY;
				read_count <= read_count + 1;
			end
		end else if (!r.rvalid) begin
			if (delay == 0) begin
				r.rvalid <= 1'b1;
				r.rdata <= line_at(req_addr);
				r.rresp <= (req_addr[31:3] == ERR_ADDR[31:3]) ? fetch_pkg::SLVERR : fetch_pkg::OKAY;
			end else begin
				delay <= delay - 1;
			end
		end else if (rready) begin
			// Response taken, ready for the next address
			r.rvalid <= 1'b0;
			busy <= 1'b0;
		end
	end

endmodule

/* verification/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

	localparam int PARCELS = 256;
	localparam fetch_pkg::addr_t ERR_ADDR = 32'h1c0;
	localparam fetch_pkg::addr_t FAULT_ADDR = 32'h132;
	localparam int NUM_ROWS = 7;
	localparam int WAIT_LIMIT = 300; // Cycles before any wait gives up

	typedef enum logic [1:0] {EXC_NONE, EXC_ODD_PC, EXC_LENGTH, EXC_BUS} exc_kind_e;

	typedef struct packed {
		fetch_pkg::addr_t pc;
		logic [7:0] count;       // Outputs expected before any exception
		logic [6:0] stall_pct;
		logic flush_mid;         // Flush once a bus read is in flight
		logic [7:0] flush_after;
		fetch_pkg::addr_t flush_pc;
		logic same_reads;        // Every line must already sit in the cache
		exc_kind_e exc;
	} test_row_t;

	logic clk;
	logic rst;
	logic flush;
	fetch_pkg::addr_t pc;
	logic consumer_stall;
	fetch_pkg::fetch_out_t out;
	logic out_valid;
	fetch_pkg::axi_ar_t ar;
	logic arready;
	fetch_pkg::axi_r_t r;
	logic rready;
	int unsigned read_count;

	test_row_t rows [NUM_ROWS];
	int seed = 63;
	int mismatches = 0;
	int failures = 0;
	logic held; // Output was stalled at the coming edge
	fetch_pkg::fetch_out_t held_out;

	fetch_top i_fetch_top (.*);

	axi_rom_model #(.PARCELS(PARCELS), .ERR_ADDR(ERR_ADDR), .FAULT_ADDR(FAULT_ADDR)) i_rom (.*);

	always #4 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [127:0] expected,
			input logic [127:0] got);
		mismatches++;
		$display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, expected, got);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// Reference decoder reads the image parcel by parcel
	function automatic fetch_pkg::parcel_t parcel_at(fetch_pkg::addr_t a);
		return i_rom.mem[(a >> 1) % PARCELS];
	endfunction

	// One consumer cycle, the decision applies to the next rising edge
	task automatic consumer_cycle(input int pct, output logic taken,
			output fetch_pkg::fetch_out_t item);
		@(negedge clk);
		if (held) begin
			assert (out_valid) else report_failure("out_valid dropped while the consumer stalled");
			assert (out == held_out) else report_mismatch("out", held_out, out);
		end
		consumer_stall = ($unsigned($random(seed)) % 100) < pct;
		taken = out_valid && !consumer_stall;
		item = out;
		held = out_valid && consumer_stall;
		held_out = out;
	endtask

	task automatic accept_item(input int pct, output fetch_pkg::fetch_out_t item, output logic ok);
		logic taken;
		int waited;
		ok = 1'b0;
		for (waited = 0; waited < WAIT_LIMIT && !ok; waited++) begin
			consumer_cycle(pct, taken, item);
			ok = taken;
		end
		if (!ok)
			report_failure("no output was accepted before the timeout");
	endtask

	// Called right after a falling edge, flush lasts one cycle
	task automatic start_fetch(input fetch_pkg::addr_t start);
		flush = 1'b1;
		pc = start;
		consumer_stall = 1'b1;
		held = 1'b0;
		@(negedge clk);
		assert (!out_valid && !ar.arvalid && !rready)
			else report_failure("output or bus handshake active during flush");
		flush = 1'b0;
	endtask

	// The consumer keeps taking, so fetch runs on until its next line miss
	task automatic wait_for_bus_read();
		int waited;
		for (waited = 0; waited < WAIT_LIMIT && !rready; waited++)
			@(negedge clk);
		if (!rready)
			report_failure("no bus read was in flight for the mid-stream flush");
	endtask

	task automatic drain_bus();
		int waited;
		int quiet;
		quiet = 0;
		for (waited = 0; waited < WAIT_LIMIT && quiet < 8; waited++) begin
			@(negedge clk);
			consumer_stall = 1'b1;
			quiet = (ar.arvalid || rready) ? 0 : quiet + 1;
		end
		if (quiet < 8)
			report_failure("the bus did not go quiet at the end of a row");
	endtask

	task automatic expect_no_output(input int cycles);
		int i;
		for (i = 0; i < cycles; i++) begin
			@(negedge clk);
			consumer_stall = 1'b0;
			assert (!out_valid) else report_failure("out_valid rose again after an exception");
		end
	endtask

	task automatic run_row(input test_row_t row);
		fetch_pkg::fetch_out_t item;
		fetch_pkg::addr_t a;
		fetch_pkg::instr_t exp_instr;
		fetch_pkg::parcel_t low;
		int unsigned reads_before;
		logic ok;
		int k;
		start_fetch(row.pc);
		reads_before = read_count;
		a = row.pc;
		ok = 1'b1;
		for (k = 0; k < row.count && ok; k++) begin
			if (row.flush_mid && k == row.flush_after) begin
				wait_for_bus_read();
				start_fetch(row.flush_pc);
				a = row.flush_pc;
			end
			accept_item(row.stall_pct, item, ok);
			if (ok) begin
				low = parcel_at(a);
				exp_instr = (low[1:0] != 2'b11) ? {16'h0, low} : {parcel_at(a + 32'd2), low};
				assert (item.instr_addr == a) else report_mismatch("out.instr_addr", a, item.instr_addr);
				assert (item.instruction == exp_instr)
					else report_mismatch("out.instruction", exp_instr, item.instruction);
				a = a + ((low[1:0] != 2'b11) ? 32'd2 : 32'd4);
				assert (item.next_addr == a) else report_mismatch("out.next_addr", a, item.next_addr);
				assert (!item.exception) else report_mismatch("out.exception", 0, item.exception);
			end
		end
		if (ok && row.exc != EXC_NONE) begin
			accept_item(0, item, ok);
			if (ok) begin
				assert (item.exception) else report_mismatch("out.exception", 1, item.exception);
				assert (item.instr_addr == a) else report_mismatch("out.instr_addr", a, item.instr_addr);
				expect_no_output(40);
			end
		end
		drain_bus();
		if (row.same_reads)
			assert (read_count == reads_before)
				else report_mismatch("read_count", reads_before, read_count);
	endtask

	initial begin : main
		int i;
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		pc = '0;
		consumer_stall = 1'b1;
		held = 1'b0;
		// pc, count, stall %, flush, after, flush pc, same reads, exception
		rows[0] = '{32'h000, 8'd30, 7'd0, 1'b0, 8'd0, 32'h000, 1'b0, EXC_NONE};
		rows[1] = '{32'h000, 8'd30, 7'd0, 1'b0, 8'd0, 32'h000, 1'b1, EXC_NONE};
		rows[2] = '{32'h000, 8'd30, 7'd50, 1'b0, 8'd0, 32'h000, 1'b0, EXC_NONE};
		rows[3] = '{32'h0fc, 8'd15, 7'd0, 1'b1, 8'd3, 32'h168, 1'b0, EXC_NONE};
		rows[4] = '{32'h121, 8'd0, 7'd0, 1'b0, 8'd0, 32'h000, 1'b0, EXC_ODD_PC};
		rows[5] = '{32'h120, 8'd6, 7'd30, 1'b0, 8'd0, 32'h000, 1'b0, EXC_LENGTH};
		rows[6] = '{32'h1b0, 8'd5, 7'd0, 1'b0, 8'd0, 32'h000, 1'b0, EXC_BUS};
		repeat (16) @(negedge clk);
		rst = 1'b0;
		for (i = 0; i < NUM_ROWS; i++)
			run_row(rows[i]);
		$display("Errors: %0d wrong values, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
